/* front_end.f */
verilog/fe_cfg_pkg.sv
verilog/fe_isa_pkg.sv
verilog/fe_lane_if.sv
verilog/fetch_compactor.sv
verilog/inst_buffer.sv
verilog/operand_decoder.sv
verilog/redirect_control.sv
verilog/front_end_top.sv
verification/front_end_checker.sv
verification/front_end_tb.sv

/* Bender.yml */
package:
  name: front_end

sources:
  - verilog/fe_cfg_pkg.sv
  - verilog/fe_isa_pkg.sv
  - verilog/fe_lane_if.sv
  - verilog/fetch_compactor.sv
  - verilog/inst_buffer.sv
  - verilog/operand_decoder.sv
  - verilog/redirect_control.sv
  - verilog/front_end_top.sv
  - target: test
    files:
      - verification/front_end_checker.sv
      - verification/front_end_tb.sv

/* verification/front_end_tb.sv */
/*
 * front end testbench
 * table driven fetch packets and commit events, random decode stalls
 */
`timescale 1ns/1ps
`default_nettype none

module front_end_tb;

  localparam int FW = 2;
  localparam int DW = 2;

  typedef struct packed {
    logic        is_cmt;
    logic        hold;
    logic        irq;
    logic [1:0]  mask;
    logic [2:0]  kind;
    logic [31:0] pc;
    logic [31:0] i0;
    logic [31:0] i1;
    logic [31:0] tgt;
  } row_t;

  logic                    clk;
  logic                    rst_n;
  logic                    fetch_valid;
  logic [FW-1:0]           fetch_mask;
  logic [31:0]             fetch_pc;
  logic [FW-1:0][31:0]     fetch_instr;
  logic                    fetch_ready;
  logic [DW-1:0]           dec_valid;
  logic [DW-1:0][31:0]     dec_pc;
  logic [DW-1:0][31:0]     dec_instr;
  logic [DW-1:0][4:0]      dec_src0;
  logic [DW-1:0][4:0]      dec_src1;
  logic [DW-1:0][4:0]      dec_dest;
  logic                    dec_ready;
  logic                    cmt_valid;
  fe_isa_pkg::flush_kind_e cmt_kind;
  logic [31:0]             cmt_pc;
  logic [31:0]             cmt_br_target;
  logic [31:0]             csr_eentry;
  logic [31:0]             csr_tlbrentry;
  logic [31:0]             csr_era;
  logic                    irq_pending;
  logic                    redirect_valid;
  logic [31:0]             redirect_target;
  logic                    fetch_next;

  row_t        rows[$];
  string       row_names[$];
  int          row_idx = 0;
  int          tb_errs = 0;
  int          total;
  int          waited;
  logic        hold = 1'b0;
  logic        table_ready = 1'b0;
  logic [31:0] lfsr = 32'h86fd_2427;
  row_t        r;

  front_end_top #(.FETCH_WIDTH(FW), .DECODE_WIDTH(DW), .IBUF_DEPTH(8)) dut0 (
    .clk(clk), .rst_n(rst_n),
    .fetch_valid_i(fetch_valid), .fetch_mask_i(fetch_mask), .fetch_pc_i(fetch_pc),
    .fetch_instr_i(fetch_instr), .fetch_ready_o(fetch_ready),
    .dec_valid_o(dec_valid), .dec_pc_o(dec_pc), .dec_instr_o(dec_instr),
    .dec_src0_o(dec_src0), .dec_src1_o(dec_src1), .dec_dest_o(dec_dest),
    .dec_ready_i(dec_ready),
    .cmt_valid_i(cmt_valid), .cmt_kind_i(cmt_kind), .cmt_pc_i(cmt_pc),
    .cmt_br_target_i(cmt_br_target), .csr_eentry_i(csr_eentry),
    .csr_tlbrentry_i(csr_tlbrentry), .csr_era_i(csr_era), .irq_pending_i(irq_pending),
    .redirect_valid_o(redirect_valid), .redirect_target_o(redirect_target),
    .fetch_next_o(fetch_next)
  );

  front_end_checker #(.FW(FW), .DW(DW)) checker0 (
    .clk(clk), .rst_n(rst_n), .row_i(row_idx),
    .fetch_valid_i(fetch_valid), .fetch_mask_i(fetch_mask), .fetch_pc_i(fetch_pc),
    .fetch_instr_i(fetch_instr), .fetch_ready_i(fetch_ready),
    .dec_valid_i(dec_valid), .dec_pc_i(dec_pc), .dec_instr_i(dec_instr),
    .dec_src0_i(dec_src0), .dec_src1_i(dec_src1), .dec_dest_i(dec_dest),
    .dec_ready_i(dec_ready), .cmt_valid_i(cmt_valid), .cmt_kind_i(cmt_kind),
    .cmt_pc_i(cmt_pc), .cmt_br_target_i(cmt_br_target), .csr_eentry_i(csr_eentry),
    .csr_tlbrentry_i(csr_tlbrentry), .csr_era_i(csr_era), .irq_pending_i(irq_pending),
    .redirect_valid_i(redirect_valid), .redirect_target_i(redirect_target),
    .fetch_next_i(fetch_next)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one random bit per cycle for decode back-pressure
  always @(posedge clk) begin
    #1;
    lfsr = lfsr_step(lfsr);
    dec_ready = rst_n && !hold && lfsr[31];
  end

  function automatic logic [31:0] mk(input logic [5:0] opc, input logic [4:0] rk,
                                     input logic [4:0] rj, input logic [4:0] rd);
    return {opc, 11'h5a5, rk, rj, rd};
  endfunction

  task automatic add_fetch(input string n, input logic [1:0] mask, input logic [31:0] pc,
                           input logic [31:0] i0, input logic [31:0] i1, input logic hld);
    row_names.push_back(n);
    rows.push_back(row_t'{1'b0, hld, 1'b0, mask, 3'd0, pc, i0, i1, 32'd0});
  endtask

  task automatic add_cmt(input string n, input fe_isa_pkg::flush_kind_e kind,
                         input logic [31:0] pc, input logic [31:0] tgt, input logic irq,
                         input logic hld);
    row_names.push_back(n);
    rows.push_back(row_t'{1'b1, hld, irq, 2'b00, 3'(kind), pc, 32'd0, 32'd0, tgt});
  endtask

  // watchdog scaled by the table length
  initial begin
    wait (table_ready);
    repeat (row_names.size() * 40 + 200) @(posedge clk);
    $display("timeout: the run did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    fetch_valid = 1'b0;
    fetch_mask = '0;
    fetch_pc = '0;
    fetch_instr = '0;
    dec_ready = 1'b0;
    cmt_valid = 1'b0;
    cmt_kind = fe_isa_pkg::FK_NONE;
    cmt_pc = '0;
    cmt_br_target = '0;
    csr_eentry = 32'h1c00_0100;
    csr_tlbrentry = 32'h1c00_0200;
    csr_era = 32'h1c00_3ff0;
    irq_pending = 1'b0;

    add_fetch("mask11", 2'b11, 32'h1000,
              mk(6'h00, 5'd3, 5'd2, 5'd1), mk(6'h0a, 5'd9, 5'd4, 5'd5), 0);
    add_fetch("mask10", 2'b10, 32'h1010,
              mk(6'h2e, 5'd1, 5'd1, 5'd1), mk(6'h13, 5'd7, 5'd6, 5'd8), 0);
    add_fetch("mask01", 2'b01, 32'h1020, mk(6'h15, 5'd11, 5'd12, 5'd13), 32'hdead_beef, 0);
    add_fetch("mask00", 2'b00, 32'h1030, 32'h0, 32'h0, 0);
    add_fetch("br_cmp", 2'b11, 32'h1040,
              mk(6'h16, 5'd14, 5'd15, 5'd16), mk(6'h1b, 5'd17, 5'd18, 5'd19), 0);
    add_fetch("unknown", 2'b11, 32'h1050,
              mk(6'h3f, 5'd20, 5'd21, 5'd22), mk(6'h01, 5'd23, 5'd24, 5'd25), 0);
    for (int k = 0; k < 7; k++) begin
      add_fetch($sformatf("fill_%0d", k), 2'b11, 32'h2000 + 32'(8 * k),
                mk(6'h00, 5'(k), 5'(k + 1), 5'(k + 2)),
                mk(6'h0a, 5'd0, 5'(k + 3), 5'(k + 4)), 1);
    end
    add_fetch("pre_flush", 2'b11, 32'h3000,
              mk(6'h00, 5'd1, 5'd2, 5'd3), mk(6'h15, 5'd0, 5'd0, 5'd0), 1);
    add_cmt("excp", fe_isa_pkg::FK_EXCP, 32'h4000, 32'h0, 0, 1);
    add_cmt("tlbr", fe_isa_pkg::FK_TLBR, 32'h4004, 32'h0, 0, 0);
    add_cmt("branch", fe_isa_pkg::FK_BRANCH, 32'h4008, 32'h5550, 0, 0);
    add_cmt("ertn", fe_isa_pkg::FK_ERTN, 32'h400c, 32'h0, 0, 0);
    add_cmt("refetch", fe_isa_pkg::FK_REFETCH, 32'h4010, 32'h0, 0, 0);
    add_cmt("idle_lock", fe_isa_pkg::FK_IDLE, 32'h4014, 32'h0, 0, 0);
    add_fetch("after_idle", 2'b11, 32'h4018,
              mk(6'h13, 5'd0, 5'd9, 5'd10), mk(6'h17, 5'd0, 5'd11, 5'd12), 0);
    add_cmt("irq_wake", fe_isa_pkg::FK_NONE, 32'h0, 32'h0, 1, 0);
    add_cmt("idle_irq", fe_isa_pkg::FK_IDLE, 32'h4020, 32'h0, 1, 0);
    add_cmt("irq_drop", fe_isa_pkg::FK_NONE, 32'h0, 32'h0, 0, 0);
    add_fetch("tail", 2'b10, 32'h4030, 32'h0, mk(6'h0a, 5'd0, 5'd31, 5'd30), 0);
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    if (dec_valid !== '0 || redirect_valid !== 1'b0 || fetch_ready !== 1'b1 ||
        fetch_next !== 1'b1) begin
      $display("outputs after reset are not in their idle state");
      tb_errs++;
    end

    for (int n = 0; n < rows.size(); n++) begin
      r = rows[n];
      @(posedge clk);
      #1;
      row_idx = n;
      hold = r.hold;
      irq_pending = r.irq;
      if (r.is_cmt) begin
        cmt_valid = 1'b1;
        cmt_kind = fe_isa_pkg::flush_kind_e'(r.kind);
        cmt_pc = r.pc;
        cmt_br_target = r.tgt;
        @(posedge clk);
        #1 cmt_valid = 1'b0;
        cmt_kind = fe_isa_pkg::FK_NONE;
      end else begin
        fetch_valid = 1'b1;
        fetch_mask = r.mask;
        fetch_pc = r.pc;
        fetch_instr = {r.i1, r.i0};
        waited = 0;
        // wait for acceptance and let decode drain after a long stall
        forever begin
          @(negedge clk);
          if (waited > 12) hold = 1'b0;
          @(posedge clk);
          if (fetch_ready) break;
          waited++;
        end
        #1 fetch_valid = 1'b0;
      end
    end

    hold = 1'b0;
    while (checker0.exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    if (!checker0.saw_full) begin
      $display("fetch_ready_o never fell while decode was stalled");
      tb_errs++;
    end
    total = checker0.mismatch_cnt + checker0.fail_cnt + tb_errs;
    $display("checks done: %0d mismatches, %0d other errors", checker0.mismatch_cnt,
             checker0.fail_cnt + tb_errs);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : front_end_tb

`default_nettype wire

/* verification/front_end_checker.sv */
/*
 * front end checker
 * snoops the DUT ports, models compaction, operand decode, redirect
 * and idle lock, and counts errors
 */
`timescale 1ns/1ps
`default_nettype none

module front_end_checker #(
  parameter int FW = 2,
  parameter int DW = 2
) (
  input wire logic                    clk,
  input wire logic                    rst_n,
  input wire logic [31:0]             row_i,
  input wire logic                    fetch_valid_i,
  input wire logic [FW-1:0]           fetch_mask_i,
  input wire logic [31:0]             fetch_pc_i,
  input wire logic [FW-1:0][31:0]     fetch_instr_i,
  input wire logic                    fetch_ready_i,
  input wire logic [DW-1:0]           dec_valid_i,
  input wire logic [DW-1:0][31:0]     dec_pc_i,
  input wire logic [DW-1:0][31:0]     dec_instr_i,
  input wire logic [DW-1:0][4:0]      dec_src0_i,
  input wire logic [DW-1:0][4:0]      dec_src1_i,
  input wire logic [DW-1:0][4:0]      dec_dest_i,
  input wire logic                    dec_ready_i,
  input wire logic                    cmt_valid_i,
  input wire fe_isa_pkg::flush_kind_e cmt_kind_i,
  input wire logic [31:0]             cmt_pc_i,
  input wire logic [31:0]             cmt_br_target_i,
  input wire logic [31:0]             csr_eentry_i,
  input wire logic [31:0]             csr_tlbrentry_i,
  input wire logic [31:0]             csr_era_i,
  input wire logic                    irq_pending_i,
  input wire logic                    redirect_valid_i,
  input wire logic [31:0]             redirect_target_i,
  input wire logic                    fetch_next_i
);

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    int          row;
  } exp_t;

  exp_t exp_q[$];
  int   mismatch_cnt = 0;
  int   fail_cnt = 0;
  logic saw_full = 1'b0;
  logic lock_model = 1'b0;

  task automatic report(input int row, input string what, input logic [31:0] exp,
                        input logic [31:0] act);
    $display("mismatch %s %s: expected %h actual %h",
             front_end_tb.row_names[row], what, exp, act);
    mismatch_cnt++;
  endtask

  // register numbers from the operand format table
  function automatic logic [14:0] regs_of(input logic [31:0] instr);
    logic [5:0] opc;
    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;
    opc = instr[31:26];
    rd  = instr[4:0];
    rj  = instr[9:5];
    rk  = instr[14:10];
    if (opc == fe_isa_pkg::OPC_3R) return {rj, rk, rd};
    if (opc == fe_isa_pkg::OPC_2RI || opc == fe_isa_pkg::OPC_JIRL) return {rj, 5'd0, rd};
    if (opc == fe_isa_pkg::OPC_BL) return {10'd0, 5'(fe_isa_pkg::REG_RA)};
    if (opc >= fe_isa_pkg::OPC_BR_LO && opc <= fe_isa_pkg::OPC_BR_HI) return {rj, rd, 5'd0};
    return 15'd0;
  endfunction

  function automatic logic [31:0] target_of(input fe_isa_pkg::flush_kind_e kind);
    case (kind)
      fe_isa_pkg::FK_TLBR:    return csr_tlbrentry_i;
      fe_isa_pkg::FK_EXCP:    return csr_eentry_i;
      fe_isa_pkg::FK_BRANCH:  return cmt_br_target_i;
      fe_isa_pkg::FK_ERTN:    return csr_era_i;
      fe_isa_pkg::FK_REFETCH: return cmt_pc_i + 32'd4;
      fe_isa_pkg::FK_IDLE:    return cmt_pc_i + 32'd4;
      default:                return 32'd0;
    endcase
  endfunction

  always @(posedge clk) begin : watch
    exp_t        e;
    logic [14:0] r;
    logic        exp_flush;
    if (rst_n) begin
      exp_flush = cmt_valid_i && cmt_kind_i != fe_isa_pkg::FK_NONE;
      if (fetch_next_i !== !lock_model) report(row_i, "fetch_next", !lock_model, fetch_next_i);
      if (cmt_valid_i && cmt_kind_i == fe_isa_pkg::FK_IDLE && !irq_pending_i) lock_model = 1'b1;
      else if (irq_pending_i) lock_model = 1'b0;
      if ((dec_valid_i & (dec_valid_i + 1'b1)) != 0) begin
        $display("decode valid lanes not contiguous from lane 0: %b", dec_valid_i);
        fail_cnt++;
      end
      if (redirect_valid_i !== exp_flush) report(row_i, "redirect_valid", exp_flush,
                                                 redirect_valid_i);
      if (redirect_valid_i) begin
        if (redirect_target_i !== target_of(cmt_kind_i))
          report(row_i, "redirect_target", target_of(cmt_kind_i), redirect_target_i);
        exp_q.delete();
      end else begin
        if (dec_ready_i) begin
          for (int k = 0; k < DW; k++) begin
            if (dec_valid_i[k]) begin
              if (exp_q.size() == 0) begin
                $display("decode popped an entry that was never expected, pc %h", dec_pc_i[k]);
                fail_cnt++;
              end else begin
                e = exp_q.pop_front();
                r = regs_of(e.instr);
                if (dec_pc_i[k] !== e.pc) report(e.row, "pc", e.pc, dec_pc_i[k]);
                if (dec_instr_i[k] !== e.instr) report(e.row, "instr", e.instr, dec_instr_i[k]);
                if (dec_src0_i[k] !== r[14:10]) report(e.row, "src0", r[14:10], dec_src0_i[k]);
                if (dec_src1_i[k] !== r[9:5]) report(e.row, "src1", r[9:5], dec_src1_i[k]);
                if (dec_dest_i[k] !== r[4:0]) report(e.row, "dest", r[4:0], dec_dest_i[k]);
              end
            end
          end
        end
        // masked lanes vanish and each pc keeps its original slot
        if (fetch_valid_i && fetch_ready_i) begin
          for (int i = 0; i < FW; i++) begin
            if (fetch_mask_i[i]) exp_q.push_back(exp_t'{fetch_pc_i + 32'(4 * i),
                                                         fetch_instr_i[i], row_i});
          end
        end
      end
      if (!fetch_ready_i && !redirect_valid_i) saw_full = 1'b1;
    end
  end

endmodule : front_end_checker

`default_nettype wire

/* verilog/front_end_top.sv */
/*
 * CPU front end top level
 * fetch packet compaction, instruction buffer, operand decode and
 * commit-driven redirect
 */
`timescale 1ns/1ps
`default_nettype none

module front_end_top #(
  parameter int FETCH_WIDTH  = fe_cfg_pkg::FETCH_WIDTH_DEF,
  parameter int DECODE_WIDTH = fe_cfg_pkg::DECODE_WIDTH_DEF,
  parameter int IBUF_DEPTH   = fe_cfg_pkg::IBUF_DEPTH_DEF
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  // fetch side
  input  logic                                            fetch_valid_i,
  input  logic [FETCH_WIDTH-1:0]                          fetch_mask_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]                     fetch_pc_i,
  input  logic [FETCH_WIDTH-1:0][fe_cfg_pkg::XLEN-1:0]    fetch_instr_i,
  output logic                                            fetch_ready_o,
  // decode side
  output logic [DECODE_WIDTH-1:0]                         dec_valid_o,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::XLEN-1:0]   dec_pc_o,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::XLEN-1:0]   dec_instr_o,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::AREG_W-1:0] dec_src0_o,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::AREG_W-1:0] dec_src1_o,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::AREG_W-1:0] dec_dest_o,
  input  logic                                            dec_ready_i,
  // commit side
  input  logic                                            cmt_valid_i,
  input  fe_isa_pkg::flush_kind_e                         cmt_kind_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]                     cmt_pc_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]                     cmt_br_target_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]                     csr_eentry_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]                     csr_tlbrentry_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]                     csr_era_i,
  input  logic                                            irq_pending_i,
  output logic                                            redirect_valid_o,
  output logic [fe_cfg_pkg::XLEN-1:0]                     redirect_target_o,
  output logic                                            fetch_next_o
);

  logic                                          flush;
  fe_cfg_pkg::ibuf_entry_t [DECODE_WIDTH-1:0]    rd_data;
  logic [DECODE_WIDTH-1:0][fe_cfg_pkg::XLEN-1:0] rd_instr;

  fe_lane_if #(.LANES(FETCH_WIDTH)) ibuf_wr ();

  fetch_compactor #(
    .FETCH_WIDTH (FETCH_WIDTH)
  ) u_compactor (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush),
    .fetch_valid_i (fetch_valid_i),
    .fetch_mask_i  (fetch_mask_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .wr            (ibuf_wr.src)
  );

  inst_buffer #(
    .FETCH_WIDTH  (FETCH_WIDTH),
    .DECODE_WIDTH (DECODE_WIDTH),
    .IBUF_DEPTH   (IBUF_DEPTH)
  ) u_ibuf (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush),
    .wr         (ibuf_wr.dst),
    .rd_valid_o (dec_valid_o),
    .rd_data_o  (rd_data),
    .rd_ready_i (dec_ready_i)
  );

  // split buffer entries onto the decode lanes
  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      dec_pc_o[k] = rd_data[k].pc;
      rd_instr[k] = rd_data[k].instr;
    end
  end

  assign dec_instr_o = rd_instr;

  operand_decoder #(
    .DECODE_WIDTH (DECODE_WIDTH)
  ) u_opnd_dec (
    .instr_i (rd_instr),
    .src0_o  (dec_src0_o),
    .src1_o  (dec_src1_o),
    .dest_o  (dec_dest_o)
  );

  redirect_control u_redirect (
    .clk               (clk),
    .rst_n             (rst_n),
    .cmt_valid_i       (cmt_valid_i),
    .cmt_kind_i        (cmt_kind_i),
    .cmt_pc_i          (cmt_pc_i),
    .cmt_br_target_i   (cmt_br_target_i),
    .csr_eentry_i      (csr_eentry_i),
    .csr_tlbrentry_i   (csr_tlbrentry_i),
    .csr_era_i         (csr_era_i),
    .irq_pending_i     (irq_pending_i),
    .flush_o           (flush),
    .redirect_target_o (redirect_target_o),
    .fetch_next_o      (fetch_next_o)
  );

  assign redirect_valid_o = flush;

endmodule : front_end_top

`default_nettype wire

/* verilog/redirect_control.sv */
/*
 * commit redirect control
 * turns a committing flush into a global flush and a new fetch target,
 * and holds fetch after an idle until an interrupt arrives
 */
`timescale 1ns/1ps
`default_nettype none

module redirect_control (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmt_valid_i,
  input  fe_isa_pkg::flush_kind_e     cmt_kind_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] cmt_pc_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] cmt_br_target_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] csr_eentry_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] csr_tlbrentry_i,
  input  logic [fe_cfg_pkg::XLEN-1:0] csr_era_i,
  input  logic                        irq_pending_i,
  output logic                        flush_o,
  output logic [fe_cfg_pkg::XLEN-1:0] redirect_target_o,
  output logic                        fetch_next_o
);

  localparam logic [fe_cfg_pkg::XLEN-1:0] INSTR_BYTES = 4;

  logic idle_commit;
  logic idle_lock;

  assign flush_o     = cmt_valid_i && (cmt_kind_i != fe_isa_pkg::FK_NONE);
  assign idle_commit = cmt_valid_i && (cmt_kind_i == fe_isa_pkg::FK_IDLE);

  // redirect target by flush kind
  always_comb begin
    case (cmt_kind_i)
      fe_isa_pkg::FK_TLBR:    redirect_target_o = csr_tlbrentry_i;
      fe_isa_pkg::FK_EXCP:    redirect_target_o = csr_eentry_i;
      fe_isa_pkg::FK_BRANCH:  redirect_target_o = cmt_br_target_i;
      fe_isa_pkg::FK_ERTN:    redirect_target_o = csr_era_i;
      // restart right behind the committing instruction
      fe_isa_pkg::FK_REFETCH,
      fe_isa_pkg::FK_IDLE:    redirect_target_o = cmt_pc_i + INSTR_BYTES;
      default:                redirect_target_o = '0;
    endcase
  end

  // ==========================================================================
  // idle lock
  // ==========================================================================

  // a pending interrupt wins over a new idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_lock <= 1'b0;
    end else if (idle_commit && !irq_pending_i) begin
      idle_lock <= 1'b1;
    end else if (irq_pending_i) begin
      idle_lock <= 1'b0;
    end
  end

  assign fetch_next_o = !idle_lock;

  kind_known: assert property (@(posedge clk) disable iff (!rst_n)
    cmt_valid_i |-> !$isunknown(cmt_kind_i));

endmodule : redirect_control

`default_nettype wire

/* verilog/operand_decoder.sv */
/*
 * operand decoder
 * looks up the operand format and extracts source and destination registers
 */
`timescale 1ns/1ps
`default_nettype none

module operand_decoder #(
  parameter int DECODE_WIDTH = fe_cfg_pkg::DECODE_WIDTH_DEF
) (
  input  logic [DECODE_WIDTH-1:0][fe_cfg_pkg::XLEN-1:0]   instr_i,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::AREG_W-1:0] src0_o,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::AREG_W-1:0] src1_o,
  output logic [DECODE_WIDTH-1:0][fe_cfg_pkg::AREG_W-1:0] dest_o
);

  // major opcode to operand format, branch compares share a range
  function automatic fe_isa_pkg::opnd_fmt_e fmt_of(input logic [5:0] opc);
    fe_isa_pkg::opnd_fmt_e fmt;
    case (opc) inside
      fe_isa_pkg::OPC_3R:   fmt = fe_isa_pkg::FMT_3R;
      fe_isa_pkg::OPC_2RI:  fmt = fe_isa_pkg::FMT_2RI;
      fe_isa_pkg::OPC_JIRL: fmt = fe_isa_pkg::FMT_JIRL;
      fe_isa_pkg::OPC_BL:   fmt = fe_isa_pkg::FMT_BL;
      [fe_isa_pkg::OPC_BR_LO:fe_isa_pkg::OPC_BR_HI]: fmt = fe_isa_pkg::FMT_BR_CMP;
      default:              fmt = fe_isa_pkg::FMT_NONE;
    endcase
    return fmt;
  endfunction

  always_comb begin : extract
    logic [fe_cfg_pkg::AREG_W-1:0] rd;
    logic [fe_cfg_pkg::AREG_W-1:0] rj;
    logic [fe_cfg_pkg::AREG_W-1:0] rk;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      rd        = instr_i[i][4:0];
      rj        = instr_i[i][9:5];
      rk        = instr_i[i][14:10];
      src0_o[i] = '0;
      src1_o[i] = '0;
      dest_o[i] = '0;
      case (fmt_of(instr_i[i][31:26]))
        fe_isa_pkg::FMT_3R: begin
          src0_o[i] = rj;
          src1_o[i] = rk;
          dest_o[i] = rd;
        end
        fe_isa_pkg::FMT_2RI, fe_isa_pkg::FMT_JIRL: begin
          src0_o[i] = rj;
          dest_o[i] = rd;
        end
        fe_isa_pkg::FMT_BL: begin
          dest_o[i] = fe_isa_pkg::REG_RA;
        end
        // compare branches read rd as their second source
        fe_isa_pkg::FMT_BR_CMP: begin
          src0_o[i] = rj;
          src1_o[i] = rd;
        end
        default: begin
          // unknown opcode names no registers
        end
      endcase
    end
  end

endmodule : operand_decoder

`default_nettype wire

/* verilog/inst_buffer.sv */
/*
 * in-order instruction buffer
 * takes several lanes per cycle and presents the oldest entries to decode
 */
`timescale 1ns/1ps
`default_nettype none

module inst_buffer #(
  parameter int FETCH_WIDTH  = fe_cfg_pkg::FETCH_WIDTH_DEF,
  parameter int DECODE_WIDTH = fe_cfg_pkg::DECODE_WIDTH_DEF,
  parameter int IBUF_DEPTH   = fe_cfg_pkg::IBUF_DEPTH_DEF
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       flush_i,
  fe_lane_if.dst                                     wr,
  output logic [DECODE_WIDTH-1:0]                    rd_valid_o,
  output fe_cfg_pkg::ibuf_entry_t [DECODE_WIDTH-1:0] rd_data_o,
  input  logic                                       rd_ready_i
);

  // pointers wrap on their own width, so the depth is a power of two
  localparam int PTR_W = $clog2(IBUF_DEPTH);
  localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

  fe_cfg_pkg::ibuf_entry_t mem [IBUF_DEPTH];
  logic [PTR_W-1:0]        head;
  logic [PTR_W-1:0]        tail;
  logic [CNT_W-1:0]        count;
  logic                    wr_fire;
  logic [CNT_W-1:0]        wr_num;
  logic [CNT_W-1:0]        rd_num;

  // ready only when a whole packet fits
  assign wr.wready = count <= CNT_W'(IBUF_DEPTH - FETCH_WIDTH);
  assign wr_fire   = |wr.wvalid && wr.wready;
  assign wr_num    = wr_fire ? CNT_W'($countones(wr.wvalid)) : '0;
  // every valid read lane pops together
  assign rd_num    = rd_ready_i ? CNT_W'($countones(rd_valid_o)) : '0;

  // lane k shows the k-th oldest entry
  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      rd_valid_o[k] = count > CNT_W'(k);
      rd_data_o[k]  = mem[head + PTR_W'(k)];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + PTR_W'(rd_num);
      tail  <= tail + PTR_W'(wr_num);
      count <= count + wr_num - rd_num;
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        if (wr.wvalid[k]) begin
          mem[tail + PTR_W'(k)] <= wr.wdata[k];
        end
      end
    end
  end

  // a write held off by back-pressure stays on the lanes until it is taken
  held_write_stable: assert property (@(posedge clk) disable iff (!rst_n)
    |wr.wvalid && !wr.wready && !flush_i |=> $stable(wr.wvalid) && $stable(wr.wdata));

  count_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(IBUF_DEPTH));

endmodule : inst_buffer

`default_nettype wire

/* verilog/fetch_compactor.sv */
/*
 * fetch packet register and lane compaction
 * holds one packet and packs its valid lanes into buffer write lanes
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_compactor #(
  parameter int FETCH_WIDTH = fe_cfg_pkg::FETCH_WIDTH_DEF
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         flush_i,
  input  logic                                         fetch_valid_i,
  input  logic [FETCH_WIDTH-1:0]                       fetch_mask_i,
  input  logic [fe_cfg_pkg::XLEN-1:0]                  fetch_pc_i,
  input  logic [FETCH_WIDTH-1:0][fe_cfg_pkg::XLEN-1:0] fetch_instr_i,
  output logic                                         fetch_ready_o,
  fe_lane_if.src                                       wr
);

  localparam int XLEN = fe_cfg_pkg::XLEN;

  logic                                 pkt_valid;
  logic [FETCH_WIDTH-1:0]               pkt_mask;
  logic [XLEN-1:0]                      pkt_pc;
  logic [FETCH_WIDTH-1:0][XLEN-1:0]     pkt_instr;
  logic                                 accept;

  // ==========================================================================
  // packet register
  // ==========================================================================

  // held packet leaves whenever the buffer has room for a full packet
  assign fetch_ready_o = (!pkt_valid || wr.wready) && !flush_i;
  assign accept        = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_valid <= 1'b0;
    end else if (flush_i) begin
      pkt_valid <= 1'b0;
    end else if (fetch_ready_o) begin
      pkt_valid <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_mask  <= fetch_mask_i;
      pkt_pc    <= fetch_pc_i;
      pkt_instr <= fetch_instr_i;
    end
  end

  // ==========================================================================
  // compaction
  // ==========================================================================

  // squeeze out masked lanes, each keeps the pc of its original slot.
  // an all-zero mask drains the register without any write
  always_comb begin : compact
    int unsigned slot;
    slot      = 0;
    wr.wvalid = '0;
    wr.wdata  = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (pkt_valid && pkt_mask[i]) begin
        wr.wvalid[slot]      = 1'b1;
        wr.wdata[slot].pc    = pkt_pc + XLEN'(4 * i);
        wr.wdata[slot].instr = pkt_instr[i];
        slot++;
      end
    end
  end

  // nothing fetched before a redirect may reach the buffer afterwards
  flush_drops_packet: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> !pkt_valid && !(|wr.wvalid));

endmodule : fetch_compactor

`default_nettype wire

/* verilog/fe_lane_if.sv */
/*
 * multi-lane write interface between fetch compaction and the
 * instruction buffer, valid lanes packed from lane 0
 */
`timescale 1ns/1ps
`default_nettype none

interface fe_lane_if #(
  parameter int LANES = fe_cfg_pkg::FETCH_WIDTH_DEF
) ();

  // per-lane valid, always a contiguous group from lane 0
  logic [LANES-1:0]                    wvalid;
  fe_cfg_pkg::ibuf_entry_t [LANES-1:0] wdata;
  // room for a whole packet, independent of wvalid
  logic                                wready;

  modport src (
    output wvalid,
    output wdata,
    input  wready
  );

  modport dst (
    input  wvalid,
    input  wdata,
    output wready
  );

endinterface : fe_lane_if

`default_nettype wire

/* verilog/fe_isa_pkg.sv */
/*
 * front end ISA definitions
 * major opcodes, operand formats, commit flush kinds and fixed registers
 */
`default_nettype none

package fe_isa_pkg;

  // major opcode field instr[31:26]
  localparam logic [5:0] OPC_3R    = 6'h00;
  localparam logic [5:0] OPC_2RI   = 6'h0A;
  localparam logic [5:0] OPC_JIRL  = 6'h13;
  localparam logic [5:0] OPC_BL    = 6'h15;
  localparam logic [5:0] OPC_BR_LO = 6'h16;
  localparam logic [5:0] OPC_BR_HI = 6'h1B;

  // how an instruction names its registers
  typedef enum logic [2:0] {
    FMT_NONE   = 3'd0,
    FMT_3R     = 3'd1,
    FMT_2RI    = 3'd2,
    FMT_JIRL   = 3'd3,
    FMT_BL     = 3'd4,
    FMT_BR_CMP = 3'd5
  } opnd_fmt_e;

  // why the committing instruction flushes the pipe
  typedef enum logic [2:0] {
    FK_NONE    = 3'd0,
    FK_EXCP    = 3'd1,
    FK_TLBR    = 3'd2,
    FK_BRANCH  = 3'd3,
    FK_ERTN    = 3'd4,
    FK_REFETCH = 3'd5,
    FK_IDLE    = 3'd6
  } flush_kind_e;

  // link register written by BL
  localparam logic [fe_cfg_pkg::AREG_W-1:0] REG_RA = 1;

endpackage : fe_isa_pkg

`default_nettype wire

/* verilog/fe_cfg_pkg.sv */
/*
 * front end configuration
 * datapath widths, default sizes and the instruction buffer entry
 */
`default_nettype none

package fe_cfg_pkg;

  // address and instruction width
  localparam int XLEN = 32;

  // default sizes, the top level passes its own values down
  localparam int FETCH_WIDTH_DEF  = 2;
  localparam int DECODE_WIDTH_DEF = 2;
  localparam int IBUF_DEPTH_DEF   = 8;

  // architectural register number
  localparam int AREG_W = 5;

  // one buffered instruction
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } ibuf_entry_t;

endpackage : fe_cfg_pkg

`default_nettype wire
